// ==== verilog.f ====
src/cpuPkg.sv
src/ctrlIf.sv
src/controlSequencer.sv
src/busMux.sv
src/registerFile.sv
src/aluUnit.sv
src/memoryInterface.sv
src/singleBusCpu.sv
sim/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module cpuTb -o cpuTb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' sim.log; then
    exit 1
fi
exit 0

// ==== sim/cpuTb.sv ====
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int resetCycles   = 4;
    localparam int fixedRows     = 8;
    localparam int randomRows    = 6;
    localparam int numRows       = fixedRows + randomRows;
    localparam int progLength    = 3;                   // ldi, ldi, alu op before halt
    localparam int timeoutCycles = numRows * 40 + resetCycles + 2 * 16;    // plus two scans

    logic                  clock = 1'b0;
    logic                  rstN;
    logic                  start;
    logic [wordWidth-1:0]  memReadData;
    logic [fieldWidth-1:0] dbgSel;
    logic [wordWidth-1:0]  memAddr;
    logic                  memRead;
    logic                  done;
    logic [wordWidth-1:0]  dbgData;

    logic [wordWidth-1:0] mem [64];                     // word memory, combinational read
    logic [wordWidth-1:0] model [16];                   // expected register contents
    opcodeT               aluOps [4] = '{opAnd, opOr, opAdd, opSub};

    // ------------------------------------------------------------
    // test table
    // ------------------------------------------------------------
    string                rowName [numRows];
    opcodeT               rowOp   [numRows];
    logic [3:0]           rowRa   [numRows];
    logic [3:0]           rowRb   [numRows];
    logic [3:0]           rowRc   [numRows];
    logic [wordWidth-1:0] rowA    [numRows];            // loaded into Rb
    logic [wordWidth-1:0] rowB    [numRows];            // loaded into Rc
    int                   rowCount   = 0;
    int                   errors     = 0;
    int                   checks     = 0;
    int                   cycleCount = 0;
    logic [31:0]          seed       = 32'h078515a7;

    singleBusCpu #(.numRegs(16)) dut0 (
        .clock(clock), .rstN(rstN), .start(start), .memReadData(memReadData),
        .dbgSel(dbgSel), .memAddr(memAddr), .memRead(memRead), .done(done),
        .dbgData(dbgData)
    );

    assign memReadData = memRead ? mem[memAddr[5:0]] : '0;  // answers only while read

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            $display("timeout after %0d cycles, done never came", cycleCount);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encode(input opcodeT op, input logic [3:0] ra,
                                           input logic [3:0] rb, input logic [3:0] rc);
        logic [31:0] w;
        w = '0;
        w[opLsb +: opWidth]    = op;
        w[raLsb +: fieldWidth] = ra;
        w[rbLsb +: fieldWidth] = rb;
        w[rcLsb +: fieldWidth] = rc;
        return w;
    endfunction

    // Rb op Rc, all wrapping at 32 bits
    function automatic logic [31:0] expectedResult(input opcodeT op, input logic [31:0] b,
                                                   input logic [31:0] c);
        case (op)
            opAnd:   return b & c;
            opOr:    return b | c;
            opAdd:   return b + c;
            opSub:   return b - c;
            default: return '0;
        endcase
    endfunction

    task automatic addRow(input string name, input opcodeT op, input logic [3:0] ra,
                          input logic [3:0] rb, input logic [3:0] rc,
                          input logic [31:0] a, input logic [31:0] b);
        rowName[rowCount] = name;
        rowOp[rowCount]   = op;
        rowRa[rowCount]   = ra;
        rowRb[rowCount]   = rb;
        rowRc[rowCount]   = rc;
        rowA[rowCount]    = a;
        rowB[rowCount]    = b;
        rowCount++;
    endtask

    task automatic checkValue(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", label, expected, actual);
        end
    endtask

    task automatic readReg(input logic [3:0] idx, output logic [31:0] value);
        @(posedge clock);
        dbgSel <= idx;
        @(negedge clock);
        value = dbgData;                                // settled mid cycle
    endtask

    task automatic checkAllRegs(input string label);
        logic [31:0] value;
        for (int i = 0; i < 16; i++) begin
            readReg(4'(i), value);
            checkValue($sformatf("%s r%0d", label, i), model[i], value);
        end
    endtask

    task automatic loadProgram(input int row);
        for (int i = 0; i < 64; i++) begin
            mem[i] = {opHalt, 27'(i)};                  // halt words tagged with their address
        end
        mem[0] = encode(opLdi, rowRb[row], 4'd0, 4'd0);
        mem[1] = rowA[row];
        mem[2] = encode(opLdi, rowRc[row], 4'd0, 4'd0);
        mem[3] = rowB[row];
        mem[4] = encode(rowOp[row], rowRa[row], rowRb[row], rowRc[row]);
        mem[5] = encode(opHalt, 4'd0, 4'd0, 4'd0);
    endtask

    // cycles counted from the edge that takes start up to the first cycle with done
    task automatic runProgram(output int cycles);
        cycles = 0;
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        forever begin
            @(negedge clock);
            if (done) break;
            cycles++;
            @(posedge clock);
            start <= (cycles == 7);                     // stray start mid run
        end
    endtask

    initial begin
        int          cycles;
        int          errBefore;
        logic [31:0] value;
        logic [1:0]  opBits;
        logic [11:0] regBits;
        logic [31:0] opA;
        rstN   = 1'b0;
        start  = 1'b0;
        dbgSel = '0;
        loadProgram(0);
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        addRow("and",     opAnd, 4'd1,  4'd2,  4'd3,  32'hf0f0ff00, 32'hff00f0f0);
        addRow("or",      opOr,  4'd4,  4'd5,  4'd6,  32'h12340000, 32'h00005678);
        addRow("add",     opAdd, 4'd7,  4'd8,  4'd9,  32'h00001111, 32'h00002222);
        addRow("addWrap", opAdd, 4'd10, 4'd11, 4'd12, 32'hffffffff, 32'h00000002);
        addRow("sub",     opSub, 4'd13, 4'd14, 4'd15, 32'h00000064, 32'h00000028);
        addRow("subWrap", opSub, 4'd0,  4'd1,  4'd2,  32'h00000001, 32'h00000003);
        addRow("raIsRb",  opAdd, 4'd3,  4'd3,  4'd4,  32'h0000000a, 32'h00000005);
        addRow("raIsRc",  opSub, 4'd5,  4'd6,  4'd5,  32'h00000100, 32'h00000001);
        for (int i = 0; i < randomRows; i++) begin
            seed    = lcgStep(seed);
            opBits  = seed[31:30];
            regBits = seed[27:16];                      // Ra, Rb, Rc nibbles
            seed    = lcgStep(seed);
            opA     = seed;
            seed    = lcgStep(seed);
            addRow($sformatf("random%0d", i), aluOps[opBits], regBits[11:8], regBits[7:4],
                   regBits[3:0], opA, seed);
        end

        repeat (resetCycles) @(posedge clock);
        rstN <= 1'b1;
        @(negedge clock);
        checkValue("reset memRead", 32'd0, 32'(memRead));
        checkValue("reset done", 32'd0, 32'(done));
        checkAllRegs("reset");
        $display("test reset finished, %0d errors", errors);

        // ------------------------------------------------------------
        // one program per row
        // ------------------------------------------------------------
        for (int r = 0; r < rowCount; r++) begin
            errBefore = errors;
            loadProgram(r);
            model[rowRb[r]] = rowA[r];
            model[rowRc[r]] = rowB[r];                  // Rc wins when Rb equals Rc
            model[rowRa[r]] = expectedResult(rowOp[r], model[rowRb[r]], model[rowRc[r]]);
            runProgram(cycles);
            checkValue({rowName[r], " cycles"}, 6 * progLength + 4, cycles);
            readReg(rowRa[r], value);
            checkValue({rowName[r], " Ra"}, model[rowRa[r]], value);
            readReg(rowRb[r], value);
            checkValue({rowName[r], " Rb"}, model[rowRb[r]], value);
            readReg(rowRc[r], value);
            checkValue({rowName[r], " Rc"}, model[rowRc[r]], value);
            $display("test %s finished, %0d errors", rowName[r], errors - errBefore);
        end
        checkAllRegs("final");                          // untouched registers kept their values
        $display("tests %0d, checks %0d, errors %0d", rowCount + 1, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/singleBusCpu.sv ====
`default_nettype none

module singleBusCpu #(
    parameter int numRegs = 16
) (
    input  logic                          clock,
    input  logic                          rstN,
    input  logic                          start,
    input  logic [cpuPkg::wordWidth-1:0]  memReadData,
    input  logic [cpuPkg::fieldWidth-1:0] dbgSel,
    output logic [cpuPkg::wordWidth-1:0]  memAddr,
    output logic                          memRead,
    output logic                          done,
    output logic [cpuPkg::wordWidth-1:0]  dbgData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] bus;          // the one shared bus
    logic [wordWidth-1:0] pcQ;
    logic [wordWidth-1:0] mdrQ;
    logic [wordWidth-1:0] irQ;          // back to the sequencer for decode
    logic [wordWidth-1:0] zQ;
    logic [wordWidth-1:0] regQ;

    ctrlIf ctrl0 ();

    controlSequencer #(.numRegs(numRegs)) sequencer0 (
        .clock(clock), .rstN(rstN), .start(start), .irQ(irQ), .done(done), .ctrl(ctrl0)
    );

    busMux busMux0 (
        .ctrl(ctrl0), .pcQ(pcQ), .mdrQ(mdrQ), .zQ(zQ), .regQ(regQ), .bus(bus)
    );

    registerFile #(.numRegs(numRegs)) regFile0 (
        .clock(clock), .rstN(rstN), .ctrl(ctrl0), .bus(bus), .regQ(regQ),
        .dbgSel(dbgSel), .dbgData(dbgData)
    );

    aluUnit alu0 (.clock(clock), .rstN(rstN), .ctrl(ctrl0), .bus(bus), .zQ(zQ));

    memoryInterface mem0 (
        .clock(clock), .rstN(rstN), .ctrl(ctrl0), .bus(bus), .memReadData(memReadData),
        .pcQ(pcQ), .mdrQ(mdrQ), .irQ(irQ), .memAddr(memAddr), .memRead(memRead)
    );

endmodule

`default_nettype wire

// ==== src/memoryInterface.sv ====
`default_nettype none

module memoryInterface (
    input  logic                         clock,
    input  logic                         rstN,
    ctrlIf.memory                        ctrl,
    input  logic [cpuPkg::wordWidth-1:0] bus,
    input  logic [cpuPkg::wordWidth-1:0] memReadData,
    output logic [cpuPkg::wordWidth-1:0] pcQ,
    output logic [cpuPkg::wordWidth-1:0] mdrQ,
    output logic [cpuPkg::wordWidth-1:0] irQ,
    output logic [cpuPkg::wordWidth-1:0] memAddr,
    output logic                         memRead
);
    import cpuPkg::*;

    logic [wordWidth-1:0] marQ;         // address register

    // PC, loaded with zero on start and Z during fetch
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcQ <= '0;
        end else if (ctrl.pcIn) begin
            pcQ <= bus;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            marQ <= '0;
        end else if (ctrl.marIn) begin
            marQ <= bus;
        end
    end

    // MDR only takes memory data, never the bus
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mdrQ <= '0;
        end else if (ctrl.memRead && ctrl.mdrIn) begin
            mdrQ <= memReadData;                // word answered in the same cycle
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            irQ <= '0;
        end else if (ctrl.irIn) begin
            irQ <= bus;
        end
    end

    // ------------------------------------------------------------
    // memory side
    // ------------------------------------------------------------
    assign memAddr = marQ;
    assign memRead = ctrl.memRead;

endmodule

`default_nettype wire

// ==== src/aluUnit.sv ====
`default_nettype none

module aluUnit (
    input  logic                         clock,
    input  logic                         rstN,
    ctrlIf.alu                           ctrl,
    input  logic [cpuPkg::wordWidth-1:0] bus,
    output logic [cpuPkg::wordWidth-1:0] zQ
);
    import cpuPkg::*;

    logic [wordWidth-1:0] yQ;           // first operand, held from T3
    logic [wordWidth-1:0] aluResult;

    // ------------------------------------------------------------
    // Y register
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            yQ <= '0;
        end else if (ctrl.yIn) begin
            yQ <= bus;
        end
    end

    // ------------------------------------------------------------
    // function select, second operand straight from the bus
    // ------------------------------------------------------------
    always_comb begin
        case (ctrl.aluOp)
            aluAnd:  aluResult = yQ & bus;
            aluOr:   aluResult = yQ | bus;
            aluAdd:  aluResult = yQ + bus;      // wraps at 32 bits
            aluSub:  aluResult = yQ - bus;      // Y minus bus
            aluInc:  aluResult = bus + 1'b1;    // PC increment, Y bypassed
            default: aluResult = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Z register, low word only
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            zQ <= '0;
        end else if (ctrl.zIn) begin
            zQ <= aluResult;
        end
    end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`default_nettype none

module registerFile #(
    parameter int numRegs = 16
) (
    input  logic                          clock,
    input  logic                          rstN,
    ctrlIf.regFile                        ctrl,
    input  logic [cpuPkg::wordWidth-1:0]  bus,
    output logic [cpuPkg::wordWidth-1:0]  regQ,
    input  logic [cpuPkg::fieldWidth-1:0] dbgSel,
    output logic [cpuPkg::wordWidth-1:0]  dbgData
);
    import cpuPkg::*;

    localparam int selWidth = $clog2(numRegs);  // index bits actually decoded

    logic [wordWidth-1:0] regs [numRegs];
    logic                 selValid;             // regSel names an existing register
    logic                 dbgValid;

    assign selValid = ctrl.regSel < numRegs;
    assign dbgValid = dbgSel < numRegs;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regIn && selValid) begin
            regs[ctrl.regSel[selWidth-1:0]] <= bus;
        end
    end

    // bus side read, same select as the write
    assign regQ = selValid ? regs[ctrl.regSel[selWidth-1:0]] : '0;

    // debug read, independent of the datapath
    assign dbgData = dbgValid ? regs[dbgSel[selWidth-1:0]] : '0;

endmodule

`default_nettype wire

// ==== src/busMux.sv ====
`default_nettype none

module busMux (
    ctrlIf.busSel                        ctrl,
    input  logic [cpuPkg::wordWidth-1:0] pcQ,
    input  logic [cpuPkg::wordWidth-1:0] mdrQ,
    input  logic [cpuPkg::wordWidth-1:0] zQ,
    input  logic [cpuPkg::wordWidth-1:0] regQ,
    output logic [cpuPkg::wordWidth-1:0] bus
);

    always_comb begin
        bus = '0;                       // nothing driving reads as zero
        if (ctrl.pcOut) begin
            bus = pcQ;
        end else if (ctrl.zOut) begin
            bus = zQ;
        end else if (ctrl.mdrOut) begin
            bus = mdrQ;
        end else if (ctrl.regOut) begin
            bus = regQ;
        end
    end

    // two drivers would be a contention on the real bus
    always_comb begin
        assert ($onehot0({ctrl.pcOut, ctrl.zOut, ctrl.mdrOut, ctrl.regOut}))
            else $error("more than one bus driver: pc %b z %b mdr %b reg %b",
                        ctrl.pcOut, ctrl.zOut, ctrl.mdrOut, ctrl.regOut);
    end

endmodule

`default_nettype wire

// ==== src/controlSequencer.sv ====
`default_nettype none

module controlSequencer #(
    parameter int numRegs = 16
) (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic                         start,
    input  logic [cpuPkg::wordWidth-1:0] irQ,
    output logic                         done,
    ctrlIf.sequencer                     ctrl
);
    import cpuPkg::*;

    stateT                 state;       // current step
    stateT                 nextState;
    opcodeT                opcode;      // decoded from IR
    logic [fieldWidth-1:0] raSel;
    logic [fieldWidth-1:0] rbSel;
    logic [fieldWidth-1:0] rcSel;
    logic                  isAluOp;     // register to register instruction
    aluOpT                 opAlu;       // ALU function of that instruction

    assign opcode = opcodeT'(irQ[opLsb +: opWidth]);
    assign raSel  = irQ[raLsb +: fieldWidth];
    assign rbSel  = irQ[rbLsb +: fieldWidth];
    assign rcSel  = irQ[rcLsb +: fieldWidth];

    always_comb begin
        isAluOp = 1'b1;
        opAlu   = aluAnd;
        case (opcode)
            opAnd:   opAlu = aluAnd;
            opOr:    opAlu = aluOr;
            opAdd:   opAlu = aluAdd;
            opSub:   opAlu = aluSub;
            default: isAluOp = 1'b0;    // ldi, halt and unknown codes
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------------------------------------
    // strobes per step
    // ------------------------------------------------------------
    always_comb begin
        nextState    = state;
        ctrl.pcOut   = 1'b0;
        ctrl.zOut    = 1'b0;
        ctrl.mdrOut  = 1'b0;
        ctrl.regOut  = 1'b0;
        ctrl.regIn   = 1'b0;
        ctrl.pcIn    = 1'b0;
        ctrl.marIn   = 1'b0;
        ctrl.mdrIn   = 1'b0;
        ctrl.irIn    = 1'b0;
        ctrl.yIn     = 1'b0;
        ctrl.zIn     = 1'b0;
        ctrl.memRead = 1'b0;
        ctrl.regSel  = '0;
        ctrl.aluOp   = aluAnd;
        done         = 1'b0;
        case (state)
            sIdle: begin
                if (start) begin
                    ctrl.pcIn = 1'b1;   // idle bus is zero, so PC clears
                    nextState = sT0;
                end
            end
            sT0: begin                  // PC to MAR, Z gets PC + 1
                ctrl.pcOut = 1'b1;
                ctrl.marIn = 1'b1;
                ctrl.aluOp = aluInc;
                ctrl.zIn   = 1'b1;
                nextState  = sT1;
            end
            sT1: begin                  // Z back to PC while memory is read
                ctrl.zOut    = 1'b1;
                ctrl.pcIn    = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
                nextState    = sT2;
            end
            sT2: begin
                ctrl.mdrOut = 1'b1;     // instruction word into IR
                ctrl.irIn   = 1'b1;
                nextState   = sT3;
            end
            sT3: begin
                case (opcode)
                    opLdi: begin        // address the immediate word
                        ctrl.pcOut = 1'b1;
                        ctrl.marIn = 1'b1;
                        ctrl.aluOp = aluInc;
                        ctrl.zIn   = 1'b1;
                        nextState  = sT4;
                    end
                    opAnd, opOr, opAdd, opSub: begin
                        ctrl.regOut = 1'b1;
                        ctrl.regSel = rbSel;    // Rb into Y
                        ctrl.yIn    = 1'b1;
                        nextState   = sT4;
                    end
                    opHalt:  nextState = sHalt;
                    default: nextState = sHalt; // unknown code stops the run
                endcase
            end
            sT4: begin
                if (isAluOp) begin
                    ctrl.regOut = 1'b1;
                    ctrl.regSel = rcSel;        // Rc on the bus, Y op bus into Z
                    ctrl.aluOp  = opAlu;
                    ctrl.zIn    = 1'b1;
                end else begin
                    ctrl.zOut    = 1'b1;        // step PC past the immediate
                    ctrl.pcIn    = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.mdrIn   = 1'b1;
                end
                nextState = sT5;
            end
            sT5: begin
                ctrl.zOut   = isAluOp;          // result from Z
                ctrl.mdrOut = !isAluOp;         // or immediate from MDR
                ctrl.regIn  = 1'b1;
                ctrl.regSel = raSel;
                nextState   = sT0;
            end
            sHalt: begin
                done      = 1'b1;
                nextState = sIdle;
            end
            default: nextState = sIdle;
        endcase
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    regSelRange: assert property (@(posedge clock) disable iff (!rstN)
        (ctrl.regIn || ctrl.regOut) |-> (ctrl.regSel < numRegs))
        else $error("register %0d selected with only %0d registers", ctrl.regSel, numRegs);

    donePulse: assert property (@(posedge clock) disable iff (!rstN)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

`default_nettype wire

// ==== src/ctrlIf.sv ====
`default_nettype none

interface ctrlIf;
    import cpuPkg::*;

    // bus drivers, at most one high per cycle
    logic pcOut;
    logic zOut;
    logic mdrOut;
    logic regOut;

    // register load enables
    logic regIn;
    logic pcIn;
    logic marIn;
    logic mdrIn;
    logic irIn;
    logic yIn;
    logic zIn;

    logic                  memRead;     // memory read strobe
    logic [fieldWidth-1:0] regSel;      // general register for regIn and regOut
    aluOpT                 aluOp;       // ALU function for this cycle

    modport sequencer (
        output pcOut, zOut, mdrOut, regOut,
        output regIn, pcIn, marIn, mdrIn, irIn, yIn, zIn,
        output memRead, regSel, aluOp
    );

    modport busSel  (input pcOut, zOut, mdrOut, regOut);
    modport regFile (input regIn, regSel);
    modport alu     (input yIn, zIn, aluOp);
    modport memory  (input pcIn, marIn, mdrIn, irIn, memRead);

endinterface

`default_nettype wire

// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // ------------------------------------------------------------
    // widths and instruction fields
    // ------------------------------------------------------------
    localparam int wordWidth  = 32;     // data and address width
    localparam int opWidth    = 5;      // opcode field width
    localparam int fieldWidth = 4;      // register field width
    localparam int opLsb      = 27;     // opcode sits in 31:27
    localparam int raLsb      = 23;     // destination Ra in 26:23
    localparam int rbLsb      = 19;     // first source Rb in 22:19
    localparam int rcLsb      = 15;     // second source Rc in 18:15

    // ------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------
    typedef enum logic [opWidth-1:0] {
        opLdi  = 5'd1,                  // next memory word into Ra
        opAdd  = 5'd3,
        opSub  = 5'd4,                  // Rb minus Rc
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opHalt = 5'd27                  // other codes behave the same
    } opcodeT;

    typedef enum logic [2:0] {
        aluAnd,
        aluOr,
        aluAdd,
        aluSub,
        aluInc                          // bus plus one, Y unused
    } aluOpT;

    typedef enum logic [2:0] {
        sIdle, sT0, sT1, sT2, sT3, sT4, sT5, sHalt
    } stateT;

endpackage

`default_nettype wire
